//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := legPipelineTb
FILELIST  := legPipeline.f
SIM       := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- design/executeUnit.sv
//##########################################################
// execute stage: operand B select and 64-bit ALU
// combinational, results wrap and no flags are produced
//##########################################################
`default_nettype none

module executeUnit (
  input  legDataPkg::dataWord operandA,
  input  legDataPkg::dataWord operandB,
  input  legDataPkg::dataWord immValue,
  input  logic                useImm,
  input  legIsaPkg::aluOp     op,
  output legDataPkg::dataWord result
);

  legDataPkg::dataWord operandSel;

  // immediate covers ADDI/SUBI and the load/store offset
  assign operandSel = useImm ? immValue : operandB;

  always_comb begin
    case (op)
      legIsaPkg::aluAdd: begin
        result = operandA + operandSel;
      end
      legIsaPkg::aluSub: begin
        // two's complement wrap
        result = operandA - operandSel;
      end
      legIsaPkg::aluAnd: begin
        result = operandA & operandSel;
      end
      legIsaPkg::aluOrr: begin
        result = operandA | operandSel;
      end
      legIsaPkg::aluEor: begin
        result = operandA ^ operandSel;
      end
      default: begin
        // unused encodings fall back to add
        result = operandA + operandSel;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/instructionDecoder.sv
//##########################################################
// decode stage logic: fields, immediate and control bits
// purely combinational, fed from the IF/ID latch
//##########################################################
`default_nettype none

`include "leg_cfg.svh"

module instructionDecoder (
  input  legDataPkg::instrWord instr,
  output legDataPkg::regIndex  readIndexA,
  output legDataPkg::regIndex  readIndexB,
  output legDataPkg::regIndex  destIndex,
  output legDataPkg::dataWord  immValue,
  output logic                 useImm,
  output legIsaPkg::aluOp      op,
  output logic                 regWrite,
  output logic                 isLoad,
  output logic                 isStore
);

  logic [10:0] opcode;
  legDataPkg::regIndex rn;
  legDataPkg::regIndex rm;
  legDataPkg::regIndex rd;
  legDataPkg::dataWord aluImm;
  legDataPkg::dataWord addrOffset;
  logic known;

  // field split, rd doubles as Rt for loads and stores
  assign opcode = instr[31:21];
  assign rm     = instr[20:16];
  assign rn     = instr[9:5];
  assign rd     = instr[4:0];

  // ALU immediate, zero extended 12 bits
  assign aluImm = {{(`LEG_DATA_WIDTH-12){1'b0}}, instr[21:10]};
  // DT address, signed 9 bits
  assign addrOffset = {{(`LEG_DATA_WIDTH-9){instr[20]}}, instr[20:12]};

  always_comb begin
    useImm   = 1'b0;
    op       = legIsaPkg::aluAdd;
    isLoad   = 1'b0;
    isStore  = 1'b0;
    known    = 1'b1;
    immValue = aluImm;
    // I-format first, low opcode bit is part of the immediate
    if (opcode[10:1] == legIsaPkg::OPC_ADDI[10:1]) begin
      useImm = 1'b1;
    end else if (opcode[10:1] == legIsaPkg::OPC_SUBI[10:1]) begin
      useImm = 1'b1;
      op     = legIsaPkg::aluSub;
    end else begin
      case (opcode)
        legIsaPkg::OPC_ADD: op = legIsaPkg::aluAdd;
        legIsaPkg::OPC_SUB: op = legIsaPkg::aluSub;
        legIsaPkg::OPC_AND: op = legIsaPkg::aluAnd;
        legIsaPkg::OPC_ORR: op = legIsaPkg::aluOrr;
        legIsaPkg::OPC_EOR: op = legIsaPkg::aluEor;
        legIsaPkg::OPC_LDUR: begin
          // address = Rn + offset
          useImm   = 1'b1;
          immValue = addrOffset;
          isLoad   = 1'b1;
        end
        legIsaPkg::OPC_STUR: begin
          useImm   = 1'b1;
          immValue = addrOffset;
          isStore  = 1'b1;
        end
        // anything else behaves as a nop
        default: known = 1'b0;
      endcase
    end
  end

  assign readIndexA = rn;
  // store data comes out of port B from Rt
  assign readIndexB = isStore ? rd : rm;
  assign destIndex  = rd;

  // no write for stores, unknowns or X31
  assign regWrite = known && !isStore && (rd != `LEG_ZERO_REG);

endmodule

`default_nettype wire

//--- design/legDataPkg.sv
//##########################################################
// datapath vector types shared by the core and testbench
//##########################################################
`default_nettype none

`include "leg_cfg.svh"

package legDataPkg;

  // register and memory data
  typedef logic [`LEG_DATA_WIDTH-1:0] dataWord;

  // fetch or load/store address
  typedef logic [`LEG_ADDR_WIDTH-1:0] addrWord;

  // raw instruction word
  typedef logic [`LEG_INSTR_WIDTH-1:0] instrWord;

  // register number, Rn/Rm/Rd/Rt
  typedef logic [`LEG_REG_INDEX_WIDTH-1:0] regIndex;

endpackage

`default_nettype wire

//--- design/legIsaPkg.sv
//##########################################################
// opcode constants and ALU operations for the LEGv8 subset
//##########################################################
`default_nettype none

package legIsaPkg;

  // R-format, full 11-bit match
  localparam logic [10:0] OPC_ADD  = 11'b10001011000;
  localparam logic [10:0] OPC_SUB  = 11'b11001011000;
  localparam logic [10:0] OPC_AND  = 11'b10001010000;
  localparam logic [10:0] OPC_ORR  = 11'b10101010000;
  localparam logic [10:0] OPC_EOR  = 11'b11001010000;

  // I-format, only bits [10:1] are compared
  localparam logic [10:0] OPC_ADDI = 11'b10010001000;
  localparam logic [10:0] OPC_SUBI = 11'b11010001000;

  // D-format loads and stores
  localparam logic [10:0] OPC_LDUR = 11'b11111000010;
  localparam logic [10:0] OPC_STUR = 11'b11111000000;

  // ORR X31, X31, X31
  // writes X31 so it never changes state
  localparam legDataPkg::instrWord NOP_WORD = 32'hAA1F03FF;

  // ALU function select
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOrr,
    aluEor
  } aluOp;

endpackage

`default_nettype wire

//--- design/legPipeline.sv
//##########################################################
// five-stage LEGv8 core top: PC, stage latches, mem and wb
// no forwarding or stalls, producers need 3 slots of spacing
//##########################################################
`default_nettype none

`include "leg_cfg.svh"

module legPipeline (
  input  logic                 clk,
  input  logic                 reset,
  input  legDataPkg::instrWord ibus,
  input  legDataPkg::dataWord  loadData,
  output legDataPkg::addrWord  iaddrbus,
  output legDataPkg::addrWord  daddrbus,
  output legDataPkg::dataWord  storeData,
  output logic                 storeEnable
);

  // fetch
  legDataPkg::addrWord  pc;
  legDataPkg::instrWord ifIdInstr;
  // decode outputs
  legDataPkg::regIndex  decReadA;
  legDataPkg::regIndex  decReadB;
  legDataPkg::regIndex  decDest;
  legDataPkg::dataWord  decImm;
  logic                 decUseImm;
  legIsaPkg::aluOp      decOp;
  logic                 decRegWrite;
  logic                 decIsLoad;
  logic                 decIsStore;
  legDataPkg::dataWord  regReadA;
  legDataPkg::dataWord  regReadB;
  // ID/EX
  legDataPkg::dataWord  idExA;
  legDataPkg::dataWord  idExB;
  legDataPkg::dataWord  idExImm;
  logic                 idExUseImm;
  legIsaPkg::aluOp      idExOp;
  legDataPkg::regIndex  idExDest;
  logic                 idExRegWrite;
  logic                 idExIsLoad;
  logic                 idExIsStore;
  legDataPkg::dataWord  exResult;
  // EX/MEM
  legDataPkg::dataWord  exMemResult;
  legDataPkg::dataWord  exMemStoreValue;
  legDataPkg::regIndex  exMemDest;
  logic                 exMemRegWrite;
  logic                 exMemIsLoad;
  logic                 exMemIsStore;
  // MEM/WB
  legDataPkg::dataWord  memWbResult;
  legDataPkg::dataWord  memWbLoad;
  legDataPkg::regIndex  memWbDest;
  logic                 memWbRegWrite;
  logic                 memWbIsLoad;
  legDataPkg::dataWord  wbData;

  // PC from zero, fixed step, no branches
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= pc + legDataPkg::addrWord'(`LEG_PC_STEP);
    end
  end

  assign iaddrbus = pc;

  // IF/ID, nop while in reset
  always_ff @(posedge clk) begin
    if (reset) begin
      ifIdInstr <= legIsaPkg::NOP_WORD;
    end else begin
      ifIdInstr <= ibus;
    end
  end

  instructionDecoder u_decoder (
    .instr      (ifIdInstr),
    .readIndexA (decReadA),
    .readIndexB (decReadB),
    .destIndex  (decDest),
    .immValue   (decImm),
    .useImm     (decUseImm),
    .op         (decOp),
    .regWrite   (decRegWrite),
    .isLoad     (decIsLoad),
    .isStore    (decIsStore)
  );

  // writeback port driven from MEM/WB
  registerFile u_regFile (
    .clk         (clk),
    .reset       (reset),
    .readIndexA  (decReadA),
    .readIndexB  (decReadB),
    .readDataA   (regReadA),
    .readDataB   (regReadB),
    .writeIndex  (memWbDest),
    .writeData   (wbData),
    .writeEnable (memWbRegWrite)
  );

  // ID/EX control
  always_ff @(posedge clk) begin
    if (reset) begin
      idExRegWrite <= 1'b0;
      idExIsLoad   <= 1'b0;
      idExIsStore  <= 1'b0;
    end else begin
      idExRegWrite <= decRegWrite;
      idExIsLoad   <= decIsLoad;
      idExIsStore  <= decIsStore;
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    idExA      <= regReadA;
    idExB      <= regReadB;
    idExImm    <= decImm;
    idExUseImm <= decUseImm;
    idExOp     <= decOp;
    idExDest   <= decDest;
  end

  executeUnit u_execute (
    .operandA (idExA),
    .operandB (idExB),
    .immValue (idExImm),
    .useImm   (idExUseImm),
    .op       (idExOp),
    .result   (exResult)
  );

  // EX/MEM control
  always_ff @(posedge clk) begin
    if (reset) begin
      exMemRegWrite <= 1'b0;
      exMemIsLoad   <= 1'b0;
      exMemIsStore  <= 1'b0;
    end else begin
      exMemRegWrite <= idExRegWrite;
      exMemIsLoad   <= idExIsLoad;
      exMemIsStore  <= idExIsStore;
    end
  end

  // EX/MEM payload, B operand carries the store data
  always_ff @(posedge clk) begin
    exMemResult     <= exResult;
    exMemStoreValue <= idExB;
    exMemDest       <= idExDest;
  end

  // memory stage, address is low half of the sum
  assign daddrbus    = exMemResult[`LEG_ADDR_WIDTH-1:0];
  assign storeData   = exMemStoreValue;
  assign storeEnable = exMemIsStore;

  // MEM/WB control
  always_ff @(posedge clk) begin
    if (reset) begin
      memWbRegWrite <= 1'b0;
      memWbIsLoad   <= 1'b0;
    end else begin
      memWbRegWrite <= exMemRegWrite;
      memWbIsLoad   <= exMemIsLoad;
    end
  end

  // MEM/WB payload, load word sampled same cycle as the address
  always_ff @(posedge clk) begin
    memWbResult <= exMemResult;
    memWbLoad   <= loadData;
    memWbDest   <= exMemDest;
  end

  // writeback select
  assign wbData = memWbIsLoad ? memWbLoad : memWbResult;

endmodule

`default_nettype wire

//--- design/leg_cfg.svh
//##########################################################
// widths and constants for the LEGv8 pipelined core
// included by the packages and by any module needing sizes
//##########################################################
`ifndef LEG_CFG_SVH
`define LEG_CFG_SVH

// register and data bus width
`define LEG_DATA_WIDTH 64

// instruction and data address width
`define LEG_ADDR_WIDTH 32

// instruction word width
`define LEG_INSTR_WIDTH 32

// register file size and index width
`define LEG_REG_COUNT 32
`define LEG_REG_INDEX_WIDTH 5

// X31 always reads as zero
`define LEG_ZERO_REG 31

// fetch address advance per cycle
`define LEG_PC_STEP 4

`endif

//--- design/registerFile.sv
//##########################################################
// 32 x 64 register file, two reads, one write at the edge
// X31 reads zero; same-cycle write is forwarded to reads
//##########################################################
`default_nettype none

`include "leg_cfg.svh"

module registerFile (
  input  logic                clk,
  input  logic                reset,
  input  legDataPkg::regIndex readIndexA,
  input  legDataPkg::regIndex readIndexB,
  output legDataPkg::dataWord readDataA,
  output legDataPkg::dataWord readDataB,
  input  legDataPkg::regIndex writeIndex,
  input  legDataPkg::dataWord writeData,
  input  logic                writeEnable
);

  // X0..X30 only, X31 has no storage
  legDataPkg::dataWord regs [`LEG_REG_COUNT-1];

  // zero reg, then bypass, then stored value
  function automatic legDataPkg::dataWord readPort(input legDataPkg::regIndex idx);
    legDataPkg::dataWord value;
    if (idx == `LEG_ZERO_REG) begin
      value = '0;
    end else if (writeEnable && (writeIndex == idx)) begin
      value = writeData;
    end else begin
      value = regs[idx];
    end
    return value;
  endfunction

  always_comb begin
    readDataA = readPort(readIndexA);
    readDataB = readPort(readIndexB);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `LEG_REG_COUNT - 1; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable && (writeIndex != `LEG_ZERO_REG)) begin
      regs[writeIndex] <= writeData;
    end
  end

endmodule

`default_nettype wire

//--- legPipeline.f
+incdir+design
design/legDataPkg.sv
design/legIsaPkg.sv
design/instructionDecoder.sv
design/registerFile.sv
design/executeUnit.sv
design/legPipeline.sv
verification/clockGen.sv
verification/legPipelineTb.sv

//--- verification/clockGen.sv
//##########################################################
// testbench clock (period 4) and reset held for 10 cycles
//##########################################################
`default_nettype none

module clockGen (
  output logic clk,
  output logic reset
);

  localparam int HALF_PERIOD  = 2;
  localparam int RESET_CYCLES = 10;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // released on a rising edge, like the other driven inputs
  initial begin
    reset <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

//--- verification/legPipelineTb.sv
//##########################################################
// testbench for the LEGv8 core with program feed, data memory
// model and store checks, all read from the test data file
//##########################################################
`default_nettype none

`include "leg_cfg.svh"

module legPipelineTb;

  // 8-byte words covering byte addresses 0x000..0x1f8
  localparam int MEM_WORDS = 64;

  logic                 clk;
  logic                 reset;
  legDataPkg::instrWord ibus = legIsaPkg::NOP_WORD;
  legDataPkg::dataWord  loadData;
  legDataPkg::addrWord  iaddrbus;
  legDataPkg::addrWord  daddrbus;
  legDataPkg::dataWord  storeData;
  logic                 storeEnable;

  // program and expected stores in program order
  legDataPkg::instrWord progWords [$];
  legDataPkg::addrWord  expAddrs [$];
  legDataPkg::dataWord  expDatas [$];
  legDataPkg::dataWord  mem [MEM_WORDS];

  // expected fetch address before the coming edge
  legDataPkg::addrWord  fetchAddr = '0;
  // STUR captured 1, 2 and 3 edges ago
  logic [2:0]           sturHist = 3'b000;
  logic                 primed = 1'b0;
  int                   storeCount = 0;

  clockGen u_clockGen (
    .clk   (clk),
    .reset (reset)
  );

  legPipeline u_dut (
    .clk         (clk),
    .reset       (reset),
    .ibus        (ibus),
    .loadData    (loadData),
    .iaddrbus    (iaddrbus),
    .daddrbus    (daddrbus),
    .storeData   (storeData),
    .storeEnable (storeEnable)
  );

  // combinational read in the memory stage
  assign loadData = mem[daddrbus[8:3]];

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkAddr(input string what, input legDataPkg::addrWord got,
                           input legDataPkg::addrWord want);
    if (got !== want) begin
      failRun($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, want));
    end
  endtask

  task automatic checkData(input string what, input legDataPkg::dataWord got,
                           input legDataPkg::dataWord want);
    if (got !== want) begin
      failRun($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, want));
    end
  endtask

  task automatic checkFlag(input string what, input logic got, input logic want);
    if (got !== want) begin
      failRun($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, want));
    end
  endtask

  // nop past the end of the program
  function automatic legDataPkg::instrWord wordAt(input legDataPkg::addrWord addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < progWords.size()) begin
      return progWords[idx];
    end
    return legIsaPkg::NOP_WORD;
  endfunction

  // background word for untouched memory that differs per address
  function automatic legDataPkg::dataWord fillPattern(input legDataPkg::addrWord addr);
    return {~addr, addr ^ 32'h5a5a_5a5a};
  endfunction

  task automatic readTestData();
    int fd;
    int n;
    int declared;
    string line;
    logic [7:0] tag;
    logic [63:0] first;
    logic [63:0] second;
    declared = -1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] <= fillPattern(legDataPkg::addrWord'(i * 8));
    end
    fd = $fopen("verification/testdata.txt", "r");
    if (fd == 0) begin
      failRun("could not open verification/testdata.txt");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      // skip blank and comment lines
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%c", tag);
        case (tag)
          "N": n = $sscanf(line, "%c %d", tag, declared);
          "I": begin
            n = $sscanf(line, "%c %h", tag, first);
            progWords.push_back(first[31:0]);
          end
          "M": begin
            n = $sscanf(line, "%c %h %h", tag, first, second);
            mem[first[8:3]] <= second;
          end
          "S": begin
            n = $sscanf(line, "%c %h %h", tag, first, second);
            expAddrs.push_back(first[31:0]);
            expDatas.push_back(second);
          end
          default: failRun($sformatf("unknown line in test data: %s", line));
        endcase
      end
    end
    $fclose(fd);
    if (declared != progWords.size()) begin
      failRun("program word count in test data does not match its header");
    end
  endtask

  // checks see pre-edge values and drives land after the edge
  always @(posedge clk) begin
    if (primed) begin
      // PC starts at zero and steps once per edge
      if (!reset) begin
        checkAddr("iaddrbus", iaddrbus, fetchAddr);
      end
      // store only three edges after a STUR capture
      checkFlag("storeEnable", storeEnable, sturHist[2]);
      if (storeEnable) begin
        if (storeCount >= expAddrs.size()) begin
          failRun($sformatf("store beyond the expected records at time %0t", $time));
        end else begin
          checkAddr("daddrbus", daddrbus, expAddrs[storeCount]);
          checkData("storeData", storeData, expDatas[storeCount]);
          mem[daddrbus[8:3]] <= storeData;
          storeCount <= storeCount + 1;
        end
      end
    end
    primed   <= primed | reset;
    sturHist <= {sturHist[1:0], !reset && (ibus[31:21] == legIsaPkg::OPC_STUR)};
    // IF/ID ignores ibus while in reset
    fetchAddr <= reset ? '0 : fetchAddr + `LEG_PC_STEP;
    ibus      <= wordAt(reset ? '0 : fetchAddr + `LEG_PC_STEP);
  end

  initial begin
    readTestData();
    wait (storeCount == expAddrs.size());
    // a few more edges to catch a stray store
    repeat (6) @(posedge clk);
    if (fetchAddr >= `LEG_PC_STEP * progWords.size()) begin
      $display("All checks passed");
      $finish;
    end else begin
      failRun("program did not run to its end");
    end
  end

  // program length plus drain margin
  initial begin
    @(negedge reset);
    repeat (progWords.size() + 20) @(posedge clk);
    failRun($sformatf("timeout with stores missing: %0d of %0d seen",
                      storeCount, expAddrs.size()));
  end

endmodule

`default_nettype wire

//--- verification/testdata.txt
# N count | I word (hex) | M addr data: initial memory (hex)
# S addr data: expected store, in program order (hex)
N 26
# X1=0x123, X2=0xf0, X3=0x800 zero extended, X10=0x100 base
I 91048FE1
I 9103C3E2
I 912003E3
I 910403EA
# ADD X4, SUB X5, AND X6, ORR X7, EOR X8
I 8B020024
I CB030025
I 8A020026
I AA030027
I CA020028
# STUR X4..X8 at base+0, +8, +16, +24, -8
I F8000144
I F8008145
I F8010146
I F8018147
I F81F8148
# SUBI X9, LDUR X11 [+64], ADD X31 dropped, LDUR X12 [-16]
I D1049029
I F844014B
I 8B02003F
I F85F014C
# STUR X9, X11, X31, X12 at +32, +40, +48, +56
I F8020149
I F802814B
I F803015F
I F803814C
# ADD X13 = X31 + X1, two nops, STUR X13 at -24
I 8B0103ED
I AA1F03FF
I AA1F03FF
I F81E814D
M 140 0123456789ABCDEF
M 0F0 FEDCBA9876543210
S 100 0000000000000213
S 108 FFFFFFFFFFFFF923
S 110 0000000000000020
S 118 0000000000000923
S 0F8 00000000000001D3
S 120 FFFFFFFFFFFFFFFF
S 128 0123456789ABCDEF
S 130 0000000000000000
S 138 FEDCBA9876543210
S 0E8 0000000000000123
